//--- source/alu_pkg.sv
package alu_pkg;

  // datapath width, fixed by the isa
  localparam int xlen = 32;

  // one iteration per quotient bit
  localparam int div_steps = xlen;

  typedef logic [xlen-1:0] word_t;

  // one-hot op word, msb first
  // bit positions match the decoder's 19-bit op field
  typedef struct packed {
    logic       modu;     // [18] unsigned remainder
    logic       mod;      // [17] signed remainder
    logic       divu;     // [16] unsigned quotient
    logic       div;      // [15] signed quotient
    logic [2:0] rsv_mul;  // [14:12] multiply slots, not built
    logic       lui;      // [11] pass src2
    logic       sra;      // [10]
    logic       srl;      // [9]
    logic       sll;      // [8]
    logic       xor_op;   // [7]
    logic       or_op;    // [6]
    logic       nor_op;   // [5]
    logic       and_op;   // [4]
    logic       sltu;     // [3] unsigned set-less-than
    logic       slt;      // [2] signed set-less-than
    logic       sub;      // [1]
    logic       add;      // [0]
  } alu_op_t;

  // request into the divider
  // held by the alu for as long as the op is presented
  typedef struct packed {
    word_t dividend;   // src1
    word_t divisor;    // src2
    logic  is_signed;  // div / mod
  } div_req_t;

  // divider result pair
  // valid while done is high
  typedef struct packed {
    word_t quotient;
    word_t remainder;
  } div_rsp_t;

  // div by zero:
  // quotient all ones, remainder = dividend
  // (both signed and unsigned)

  // signed results round toward zero
  // remainder follows dividend sign

endpackage

//--- source/alu_adder.sv
`timescale 1ns/1ps

module alu_adder (
  input  alu_pkg::alu_op_t alu_op,
  input  alu_pkg::word_t   src1,
  input  alu_pkg::word_t   src2,
  output alu_pkg::word_t   sum,          // add / sub result
  output logic             lt_signed,    // src1 < src2, signed
  output logic             lt_unsigned   // src1 < src2, unsigned
);

  localparam int w = alu_pkg::xlen;

  logic           do_sub;    // compares also subtract
  alu_pkg::word_t b_opnd;    // src2 or its complement
  logic [w:0]     full_sum;  // carry out on top

  assign do_sub = alu_op.sub | alu_op.slt | alu_op.sltu;

  // two's complement sub: a + ~b + 1
  assign b_opnd   = do_sub ? ~src2 : src2;
  assign full_sum = {1'b0, src1} + {1'b0, b_opnd} + {{w{1'b0}}, do_sub};

  assign sum = full_sum[w-1:0];

  // signs differ: negative src1 is the smaller
  // signs equal: difference sign decides, no overflow possible
  assign lt_signed = (src1[w-1] & ~src2[w-1])
                   | ((src1[w-1] ~^ src2[w-1]) & full_sum[w-1]);

  // borrow out of the subtract
  assign lt_unsigned = ~full_sum[w];   // no carry means src1 < src2

  // sum bits are meaningless for compares
  // only the flags are taken there

  // add alone leaves b untouched, carry in 0
  // wraparound comes for free from the dropped carry

endmodule

//--- source/alu_shifter.sv
`timescale 1ns/1ps

module alu_shifter (
  input  alu_pkg::alu_op_t alu_op,
  input  alu_pkg::word_t   src1,
  input  logic [4:0]       shamt,   // src2[4:0] only
  output alu_pkg::word_t   shifted
);

  localparam int w = alu_pkg::xlen;

  alu_pkg::word_t left_res;   // sll
  logic [2*w-1:0] ext_src;    // src1 with fill above
  logic [2*w-1:0] ext_shr;    // right shift over 64 bits
  alu_pkg::word_t right_res;  // srl / sra
  logic           fill_bit;   // sign for sra, else zero

  // logical left, zero fill from the bottom
  assign left_res = src1 << shamt;

  // sra copies the sign into the upper half
  assign fill_bit = alu_op.sra & src1[w-1];
  assign ext_src  = {{w{fill_bit}}, src1};

  // one right shifter serves both srl and sra
  assign ext_shr   = ext_src >> shamt;
  assign right_res = ext_shr[w-1:0];   // low word carries the result

  // and-or select
  // zero when no shift op is set
  assign shifted = ({w{alu_op.sll}} & left_res)
                 | ({w{alu_op.srl | alu_op.sra}} & right_res);

  // shamt 0 passes src1 through unchanged
  // shamt 31 on sra leaves all sign bits

  // shift amount is 5 bits
  // upper bits of src2 never reach here

endmodule

//--- source/int_divider.sv
`timescale 1ns/1ps

module int_divider (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,  // level, held by the alu
  input  alu_pkg::div_req_t req,
  output logic              done,   // held until start drops
  output alu_pkg::div_rsp_t rsp
);

  localparam int w      = alu_pkg::xlen;
  localparam int step_w = $clog2(alu_pkg::div_steps + 1);

  // control
  logic              busy_q;
  logic              done_q;
  logic [step_w-1:0] step_q;    // iterations done so far

  // datapath
  alu_pkg::word_t    rem_q;     // partial remainder
  alu_pkg::word_t    quo_q;     // dividend shifts out, quotient shifts in
  alu_pkg::word_t    dvs_q;     // divisor magnitude
  logic              q_neg_q;   // negate quotient at fixup
  logic              r_neg_q;   // negate remainder at fixup
  logic              dvz_q;     // divide by zero seen
  alu_pkg::div_rsp_t rsp_q;

  logic              idle;
  logic              capture;
  logic              iterate;
  logic              fixup;

  // operand signs only count for signed ops
  logic              a_neg;
  logic              b_neg;
  alu_pkg::word_t    a_mag;
  alu_pkg::word_t    b_mag;

  // one restoring step
  logic [w:0]        shl_rem;   // remainder with next dividend bit
  logic [w:0]        trial;     // shl_rem - divisor

  assign idle    = ~busy_q & ~done_q;
  assign capture = idle & start;
  assign iterate = busy_q & (step_q < step_w'(alu_pkg::div_steps));
  assign fixup   = busy_q & (step_q == step_w'(alu_pkg::div_steps));

  assign a_neg = req.is_signed & req.dividend[w-1];
  assign b_neg = req.is_signed & req.divisor[w-1];
  assign a_mag = a_neg ? -req.dividend : req.dividend;   // 0x80000000 stays as is
  assign b_mag = b_neg ? -req.divisor  : req.divisor;

  assign shl_rem = {rem_q, quo_q[w-1]};
  assign trial   = shl_rem - {1'b0, dvs_q};   // top bit set means it did not fit

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      step_q <= '0;
    end else if (capture) begin
      busy_q <= 1'b1;
      step_q <= '0;
    end else if (iterate) begin
      step_q <= step_q + 1'b1;
    end else if (fixup) begin
      busy_q <= 1'b0;
      done_q <= 1'b1;   // result registered on this same edge
    end else if (done_q && !start) begin
      done_q <= 1'b0;   // back to idle, caller dropped the op
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      rem_q   <= '0;
      quo_q   <= a_mag;
      dvs_q   <= b_mag;
      q_neg_q <= a_neg ^ b_neg;
      r_neg_q <= a_neg;             // remainder follows the dividend
      dvz_q   <= (req.divisor == '0);
    end else if (iterate) begin
      if (!trial[w]) begin
        rem_q <= trial[w-1:0];
        quo_q <= {quo_q[w-2:0], 1'b1};
      end else begin
        rem_q <= shl_rem[w-1:0];    // restore
        quo_q <= {quo_q[w-2:0], 1'b0};
      end
    end else if (fixup) begin
      // zero divisor: every trial fits, so rem_q already holds |dividend|
      // and the sign fixup below brings back the dividend itself
      rsp_q.quotient  <= dvz_q ? '1 : (q_neg_q ? -quo_q : quo_q);
      rsp_q.remainder <= r_neg_q ? -rem_q : rem_q;
    end
  end

  assign done = done_q;
  assign rsp  = rsp_q;

  // the step count tops out at one per quotient bit
  a_step_bound: assert property (
    @(posedge clk) disable iff (!rst_n)
    step_q <= step_w'(alu_pkg::div_steps)
  );

  // done only after busy has cleared at fixup
  a_done_not_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(done_q && busy_q)
  );

endmodule

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
  input  logic             clk,
  input  logic             rst_n,
  input  alu_pkg::alu_op_t alu_op,   // one-hot, held by the caller
  input  alu_pkg::word_t   src1,
  input  alu_pkg::word_t   src2,
  output alu_pkg::word_t   result,
  output logic             ready     // low while a divide is running
);

  localparam int w = alu_pkg::xlen;

  // decoded groups
  logic              op_add_sub;
  logic              op_shift;
  logic              op_quo;       // div / divu
  logic              op_rem;       // mod / modu
  logic              div_start;    // any divide flag

  // adder outputs
  alu_pkg::word_t    add_sub_res;
  logic              lt_signed;
  logic              lt_unsigned;

  alu_pkg::word_t    slt_res;
  alu_pkg::word_t    sltu_res;
  alu_pkg::word_t    and_res;
  alu_pkg::word_t    nor_res;
  alu_pkg::word_t    or_res;
  alu_pkg::word_t    xor_res;
  alu_pkg::word_t    lui_res;
  alu_pkg::word_t    shift_res;

  // divider link
  alu_pkg::div_req_t div_req;
  alu_pkg::div_rsp_t div_rsp;
  logic              div_done;

  assign op_add_sub = alu_op.add | alu_op.sub;
  assign op_shift   = alu_op.sll | alu_op.srl | alu_op.sra;
  assign op_quo     = alu_op.div | alu_op.divu;
  assign op_rem     = alu_op.mod | alu_op.modu;
  assign div_start  = op_quo | op_rem;

  alu_adder u_adder (
    .alu_op      (alu_op),
    .src1        (src1),
    .src2        (src2),
    .sum         (add_sub_res),
    .lt_signed   (lt_signed),
    .lt_unsigned (lt_unsigned)
  );

  alu_shifter u_shifter (
    .alu_op  (alu_op),
    .src1    (src1),
    .shamt   (src2[4:0]),   // upper src2 bits ignored
    .shifted (shift_res)
  );

  // src1 / src2, signedness from div or mod
  assign div_req.dividend  = src1;
  assign div_req.divisor   = src2;
  assign div_req.is_signed = alu_op.div | alu_op.mod;

  int_divider u_divider (
    .clk   (clk),
    .rst_n (rst_n),
    .start (div_start),
    .req   (div_req),
    .done  (div_done),
    .rsp   (div_rsp)
  );

  // compares give 0 or 1
  assign slt_res  = {{(w-1){1'b0}}, lt_signed};
  assign sltu_res = {{(w-1){1'b0}}, lt_unsigned};

  assign and_res = src1 & src2;
  assign or_res  = src1 | src2;
  assign nor_res = ~or_res;
  assign xor_res = src1 ^ src2;
  assign lui_res = src2;   // immediate already placed by decode

  // and-or result select
  // reserved mul bits hit no term, so a mul request reads zero
  assign result = ({w{op_add_sub}}    & add_sub_res)
                | ({w{alu_op.slt}}    & slt_res)
                | ({w{alu_op.sltu}}   & sltu_res)
                | ({w{alu_op.and_op}} & and_res)
                | ({w{alu_op.nor_op}} & nor_res)
                | ({w{alu_op.or_op}}  & or_res)
                | ({w{alu_op.xor_op}} & xor_res)
                | ({w{alu_op.lui}}    & lui_res)
                | ({w{op_shift}}      & shift_res)
                | ({w{op_quo}}        & div_rsp.quotient)
                | ({w{op_rem}}        & div_rsp.remainder);

  // single-cycle ops are always ready
  assign ready = ~div_start | div_done;

  // decoder hands over at most one op per cycle
  a_op_onehot: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(alu_op)
  );

  // no multiplier behind these bits
  a_no_mul: assert property (
    @(posedge clk) disable iff (!rst_n)
    alu_op.rsv_mul == 3'b000
  );

endmodule

//--- testbench/alu_tb_vectors.svh
`ifndef alu_tb_vectors_svh
`define alu_tb_vectors_svh

// table columns: test name, op bit, src1, src2, expected result

// bit positions inside the one-hot op word
localparam int p_add  = 0;
localparam int p_sub  = 1;
localparam int p_slt  = 2;
localparam int p_sltu = 3;
localparam int p_and  = 4;
localparam int p_nor  = 5;
localparam int p_or   = 6;
localparam int p_xor  = 7;
localparam int p_sll  = 8;
localparam int p_srl  = 9;
localparam int p_sra  = 10;
localparam int p_lui  = 11;
localparam int p_div  = 15;
localparam int p_divu = 16;
localparam int p_mod  = 17;
localparam int p_modu = 18;

// parallel columns, one row per test
string             vec_name[$];
alu_pkg::alu_op_t  vec_op[$];
alu_pkg::word_t    vec_a[$];
alu_pkg::word_t    vec_b[$];
alu_pkg::word_t    vec_exp[$];

function automatic alu_pkg::alu_op_t op_at(input int pos);
  op_at = alu_pkg::alu_op_t'(19'd1 << pos);   // single flag set
endfunction

task automatic push_vec(input string name, input int pos, input alu_pkg::word_t a,
                        input alu_pkg::word_t b, input alu_pkg::word_t exp);
  vec_name.push_back(name);
  vec_op.push_back(op_at(pos));
  vec_a.push_back(a);
  vec_b.push_back(b);
  vec_exp.push_back(exp);
endtask

task automatic build_table();
  // add / sub wraparound, compares with mixed signs
  push_vec("add_ovf",    p_add,  32'h7fffffff, 32'h00000001, 32'h80000000);
  push_vec("add_wrap",   p_add,  32'hffffffff, 32'h00000002, 32'h00000001);
  push_vec("sub_neg",    p_sub,  32'h00000005, 32'h00000007, 32'hfffffffe);
  push_vec("sub_wrap",   p_sub,  32'h80000000, 32'h00000001, 32'h7fffffff);
  push_vec("slt_m1_1",   p_slt,  32'hffffffff, 32'h00000001, 32'h00000001);
  push_vec("sltu_m1_1",  p_sltu, 32'hffffffff, 32'h00000001, 32'h00000000);
  push_vec("slt_1_m1",   p_slt,  32'h00000001, 32'hffffffff, 32'h00000000);
  push_vec("sltu_1_m1",  p_sltu, 32'h00000001, 32'hffffffff, 32'h00000001);
  push_vec("slt_equal",  p_slt,  32'h00000005, 32'h00000005, 32'h00000000);
  // bitwise on alternating patterns
  push_vec("and_alt",    p_and,  32'haaaaaaaa, 32'h5555f0f0, 32'h0000a0a0);
  push_vec("or_alt",     p_or,   32'haaaaaaaa, 32'h5555f0f0, 32'hfffffafa);
  push_vec("nor_alt",    p_nor,  32'haaaaaaaa, 32'h5555f0f0, 32'h00000505);
  push_vec("xor_alt",    p_xor,  32'haaaaaaaa, 32'h5555f0f0, 32'hffff5a5a);
  push_vec("lui_pass",   p_lui,  32'h12345678, 32'habcde000, 32'habcde000);
  // shifts of a negative word by 0, 1 and 31
  push_vec("sll_0",      p_sll,  32'h80000011, 32'h00000000, 32'h80000011);
  push_vec("sll_1",      p_sll,  32'h80000011, 32'h00000001, 32'h00000022);
  push_vec("sll_31",     p_sll,  32'h80000011, 32'h0000001f, 32'h80000000);
  push_vec("srl_0",      p_srl,  32'h80000011, 32'h00000000, 32'h80000011);
  push_vec("srl_1",      p_srl,  32'h80000011, 32'h00000001, 32'h40000008);
  push_vec("srl_31",     p_srl,  32'h80000011, 32'h0000001f, 32'h00000001);
  push_vec("sra_0",      p_sra,  32'h80000011, 32'h00000000, 32'h80000011);
  push_vec("sra_1",      p_sra,  32'h80000011, 32'h00000001, 32'hc0000008);
  push_vec("sra_31",     p_sra,  32'h80000011, 32'h0000001f, 32'hffffffff);
  push_vec("sll_hi_amt", p_sll,  32'h80000011, 32'hffffffe1, 32'h00000022);  // amount 1
  push_vec("sra_hi_amt", p_sra,  32'h80000011, 32'h00000120, 32'h80000011);  // amount 0
  // divide, rounding toward zero, remainder keeps dividend sign
  push_vec("div_p_p",    p_div,  32'h00000007, 32'h00000002, 32'h00000003);
  push_vec("mod_p_p",    p_mod,  32'h00000007, 32'h00000002, 32'h00000001);
  push_vec("div_n_p",    p_div,  32'hfffffff9, 32'h00000002, 32'hfffffffd);
  push_vec("mod_n_p",    p_mod,  32'hfffffff9, 32'h00000002, 32'hffffffff);
  push_vec("div_p_n",    p_div,  32'h00000007, 32'hfffffffe, 32'hfffffffd);
  push_vec("mod_p_n",    p_mod,  32'h00000007, 32'hfffffffe, 32'h00000001);
  push_vec("add_after",  p_add,  32'h00000010, 32'h00000020, 32'h00000030);  // right after a mod
  push_vec("div_n_n",    p_div,  32'hfffffff9, 32'hfffffffe, 32'h00000003);
  push_vec("mod_n_n",    p_mod,  32'hfffffff9, 32'hfffffffe, 32'hffffffff);
  push_vec("divu_big",   p_divu, 32'hfffffff9, 32'h00000002, 32'h7ffffffc);
  push_vec("modu_big",   p_modu, 32'hfffffff9, 32'h00000002, 32'h00000001);
  push_vec("divu_small", p_divu, 32'h00000064, 32'h00000007, 32'h0000000e);
  push_vec("modu_small", p_modu, 32'h00000064, 32'h00000007, 32'h00000002);
  push_vec("div_min_m1", p_div,  32'h80000000, 32'hffffffff, 32'h80000000);
  push_vec("mod_min_m1", p_mod,  32'h80000000, 32'hffffffff, 32'h00000000);
  // zero divisor: all ones and the dividend
  push_vec("div_by_0",   p_div,  32'hfffffff9, 32'h00000000, 32'hffffffff);
  push_vec("mod_by_0",   p_mod,  32'hfffffff9, 32'h00000000, 32'hfffffff9);
  push_vec("divu_by_0",  p_divu, 32'h00001234, 32'h00000000, 32'hffffffff);
  push_vec("modu_by_0",  p_modu, 32'h00001234, 32'h00000000, 32'h00001234);
  push_vec("sub_after",  p_sub,  32'h00000001, 32'h00000003, 32'hfffffffe);
endtask

`endif

//--- testbench/alu_tb.sv
`timescale 1ns/1ps

module alu_tb;

  localparam int ready_limit = alu_pkg::div_steps + 10;   // divide plus margin

  logic             clk = 1'b0;
  logic             rst_n;
  alu_pkg::alu_op_t alu_op;
  alu_pkg::word_t   src1;
  alu_pkg::word_t   src2;
  alu_pkg::word_t   result;
  logic             ready;

  int     tests;
  int     errors;
  bit     test_ok;   // cleared by any failed check of the current test
  integer seed;

  `include "alu_tb_vectors.svh"

  alu UUT (
    .clk    (clk),
    .rst_n  (rst_n),
    .alu_op (alu_op),
    .src1   (src1),
    .src2   (src2),
    .result (result),
    .ready  (ready)
  );

  always #10 clk = ~clk;   // 20 ns period

  task automatic check_result(input string name, input alu_pkg::word_t exp,
                              input alu_pkg::word_t act);
    if (act !== exp) begin
      $display("ERROR %s: result expected %h, actual %h", name, exp, act);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s: ready expected %b, actual %b", name, exp, act);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  // entered and left on a falling edge
  task automatic run_test(input string name, input alu_pkg::alu_op_t op,
                          input alu_pkg::word_t a, input alu_pkg::word_t b,
                          input alu_pkg::word_t exp);
    int cycles;
    bit is_div;
    is_div  = op.div | op.divu | op.mod | op.modu;
    test_ok = 1'b1;
    alu_op  = op;
    src1    = a;
    src2    = b;
    @(negedge clk);
    check_ready(name, !is_div, ready);   // divide holds ready low a full cycle
    cycles = 0;
    while (!ready && cycles < ready_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!ready) begin
      $display("%s: ready never came back within %0d cycles", name, ready_limit);
      errors++;
      test_ok = 1'b0;
    end else begin
      check_result(name, exp, result);
    end
    alu_op = '0;   // idle cycle lets the divider drop done
    @(negedge clk);
    tests++;
    if (test_ok) $display("ok    %s", name);
  endtask

  initial begin
    alu_pkg::word_t a;
    alu_pkg::word_t b;
    tests  = 0;
    errors = 0;
    seed   = 37;
    rst_n  = 1'b0;
    alu_op = '0;
    src1   = '0;
    src2   = '0;
    build_table();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int i = 0; i < vec_name.size(); i++) begin
      run_test(vec_name[i], vec_op[i], vec_a[i], vec_b[i], vec_exp[i]);
    end
    // random pairs alternate add and sub
    for (int i = 0; i < 8; i++) begin
      a = $random(seed);
      b = $random(seed);
      if (i % 2 == 0) begin
        run_test($sformatf("rand_add_%0d", i), op_at(p_add), a, b, a + b);
      end else begin
        run_test($sformatf("rand_sub_%0d", i), op_at(p_sub), a, b, a - b);
      end
    end
    $display("tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+testbench
source/alu_pkg.sv
source/alu_adder.sv
source/alu_shifter.sv
source/int_divider.sv
source/alu.sv
testbench/alu_tb.sv
